// ==== memio_consts.svh ====
`ifndef MEMIO_CONSTS_SVH
`define MEMIO_CONSTS_SVH

// upper 24 address bits of the board I/O page
`define IO_PAGE         24'hFFFFFC

// register offsets inside the I/O page
`define LED_OFS         8'h60   // write only, low 24 bits
`define SEG_OFS         8'h64   // write only, seven-segment value
`define SWITCH_OFS      8'h70   // read only, 12 switches
`define KEY_OFS         8'h74   // read only, 4 keys
`define BTN_OFS         8'h78   // read only, confirm button

// data memory size as word-index bits
`define MEM_ADDR_BITS   10      // 1024 words

// ecall services, carried on the 2-bit ecallOp
`define ECALL_PRINT_INT 2'd1    // a7 = 1, a0 to LEDs
`define ECALL_READ_INT  2'd2    // a7 = 5, switches to a0

`endif

// ==== memIoPkg.sv ====
`default_nettype none

`include "memio_consts.svh"

package memIoPkg;

    // word-addressed data memory split
    typedef struct packed {
        logic [29-`MEM_ADDR_BITS:0] upper;      // ignored, addresses wrap
        logic [`MEM_ADDR_BITS-1:0]  wordIdx;
        logic [1:0]                 byteOfs;    // always 0 for word accesses
    } memView_s;

    // I/O page split
    typedef struct packed {
        logic [23:0] page;
        logic [7:0]  ofs;
    } ioView_s;

    // one address word, decoded both ways
    typedef union packed {
        memView_s mem;
        ioView_s  io;
    } memIoAddr_u;

    // owner of the load result coming back next cycle
    typedef enum logic [1:0] {
        srcNone = 2'd0,
        srcMem  = 2'd1,
        srcIo   = 2'd2
    } readSrc_e;

endpackage

`default_nettype wire

// ==== dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memio_consts.svh"

module dataMem (
    input  logic                   clk,
    input  logic                   memWe,
    input  logic                   memRe,
    input  memIoPkg::memIoAddr_u   memAddr,
    input  logic [31:0]            memWdata,
    output logic [31:0]            memRdata
);

    localparam int Depth = 1 << `MEM_ADDR_BITS;

    logic [31:0] mem [0:Depth-1];   // block RAM, contents undefined at power-up

    logic [`MEM_ADDR_BITS-1:0] wordIdx;

    assign wordIdx = memAddr.mem.wordIdx;   // upper bits dropped, so it wraps

    // single port, write first in priority
    always_ff @(posedge clk) begin
        if (memWe) begin
            mem[wordIdx] <= memWdata;
        end
    end

    // registered read, holds last word between loads
    always_ff @(posedge clk) begin
        if (memRe) begin
            memRdata <= mem[wordIdx];
        end
    end

    // decoder gates load and store from one strobe pair
    memWeReExclusive: assert property (
        @(posedge clk) !(memWe && memRe)
    ) else $error("dataMem got write and read in the same cycle");

endmodule

`default_nettype wire

// ==== ioPorts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memio_consts.svh"

module ioPorts (
    input  logic        clk,
    input  logic        rstN,
    input  logic        ioWe,
    input  logic        ioRe,
    input  logic        ecallPrint,
    input  logic        ecallRead,
    input  logic [7:0]  ioOfs,
    input  logic [31:0] ioWdata,
    input  logic [11:0] switchIn,
    input  logic [3:0]  keyIn,
    input  logic        btnIn,
    output logic [31:0] ioRdata,
    output logic [23:0] led,
    output logic [31:0] seg
);

    // two-stage synchronizers for the board inputs
    logic [11:0] switchMeta;
    logic [11:0] switchSync;
    logic [3:0]  keyMeta;
    logic [3:0]  keySync;
    logic        btnMeta;
    logic        btnSync;

    logic ledWr;
    logic segWr;

    always_ff @(posedge clk) begin
        switchMeta <= switchIn;
        switchSync <= switchMeta;
        keyMeta    <= keyIn;
        keySync    <= keyMeta;
        btnMeta    <= btnIn;
        btnSync    <= btnMeta;
    end

    assign ledWr = ecallPrint || (ioWe && ioOfs == `LED_OFS);   // print-int drives LEDs too
    assign segWr = ioWe && ioOfs == `SEG_OFS;

    // output registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            led <= '0;
            seg <= '0;
        end else begin
            if (ledWr) begin
                led <= ioWdata[23:0];   // only 24 LEDs on the board
            end
            if (segWr) begin
                seg <= ioWdata;
            end
        end
    end

    // load result is ready the cycle after the strobe
    always_ff @(posedge clk) begin
        if (ecallRead) begin
            ioRdata <= {20'h0, switchSync};
        end else if (ioRe) begin
            case (ioOfs)
                `SWITCH_OFS: ioRdata <= {20'h0, switchSync};
                `KEY_OFS:    ioRdata <= {28'h0, keySync};
                `BTN_OFS:    ioRdata <= {31'h0, btnSync};
                default:     ioRdata <= 32'h0;  // unmapped or write-only
            endcase
        end
    end

    // ecall must have masked the core's store strobe upstream
    printNotWithStore: assert property (
        @(posedge clk) disable iff (!rstN) !(ecallPrint && ioWe)
    ) else $error("print ecall overlaps an I/O store");

endmodule

`default_nettype wire

// ==== memOrIo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memio_consts.svh"

module memOrIo (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   mRead,
    input  logic                   mWrite,
    input  logic [31:0]            aluResult,
    input  logic [31:0]            rRdata,
    input  logic                   ecallValid,
    input  logic [1:0]             ecallOp,
    input  logic [31:0]            ecallA0,
    input  logic [31:0]            memRdata,
    input  logic [31:0]            ioRdata,
    output logic                   memWe,
    output logic                   memRe,
    output memIoPkg::memIoAddr_u   memAddr,
    output logic                   ioWe,
    output logic                   ioRe,
    output logic                   ecallPrint,
    output logic                   ecallRead,
    output logic [7:0]             ioOfs,
    output logic [31:0]            memWdata,
    output logic [31:0]            ioWdata,
    output logic [31:0]            rWdata
);

    memIoPkg::memIoAddr_u addr;
    memIoPkg::readSrc_e   nextSrc;
    memIoPkg::readSrc_e   pendSrc;

    logic isIo;
    logic accessOk;

    assign addr     = aluResult;
    assign isIo     = addr.io.page == `IO_PAGE;
    assign accessOk = !ecallValid;     // a valid ecall owns the cycle

    assign ecallPrint = ecallValid && ecallOp == `ECALL_PRINT_INT;
    assign ecallRead  = ecallValid && ecallOp == `ECALL_READ_INT;

    // exactly one side sees each strobe
    assign memWe = accessOk && mWrite && !isIo;
    assign memRe = accessOk && mRead && !isIo;
    assign ioWe  = accessOk && mWrite && isIo;
    assign ioRe  = accessOk && mRead && isIo;

    assign memAddr  = addr;
    assign ioOfs    = addr.io.ofs;
    assign memWdata = rRdata;
    assign ioWdata  = ecallPrint ? ecallA0 : rRdata;   // a0 goes out to the LEDs

    always_comb begin
        if (memRe) begin
            nextSrc = memIoPkg::srcMem;
        end else if (ioRe || ecallRead) begin
            nextSrc = memIoPkg::srcIo;   // read-int comes back through ioPorts
        end else begin
            nextSrc = memIoPkg::srcNone;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pendSrc <= memIoPkg::srcNone;
        end else begin
            pendSrc <= nextSrc;
        end
    end

    // both sources are registered, so pick one cycle after the strobe
    always_comb begin
        case (pendSrc)
            memIoPkg::srcMem: rWdata = memRdata;
            memIoPkg::srcIo:  rWdata = ioRdata;
            default:          rWdata = 32'h0;
        endcase
    end

    strobesExclusive: assert property (
        @(posedge clk) disable iff (!rstN) !(mRead && mWrite)
    ) else $error("load and store strobes high together");

    pendingHasLoad: assert property (
        @(posedge clk) disable iff (!rstN)
        (pendSrc != memIoPkg::srcNone) |-> $past(mRead || ecallRead)
    ) else $error("read result pending without a load the cycle before");

endmodule

`default_nettype wire

// ==== memIoTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module memIoTop (
    input  logic        clk,
    input  logic        rstN,
    input  logic        mRead,
    input  logic        mWrite,
    input  logic [31:0] aluResult,
    input  logic [31:0] rRdata,
    input  logic        ecallValid,
    input  logic [1:0]  ecallOp,
    input  logic [31:0] ecallA0,
    input  logic [11:0] switchIn,
    input  logic [3:0]  keyIn,
    input  logic        btnIn,
    output logic [31:0] rWdata,
    output logic [23:0] led,
    output logic [31:0] seg
);

    // decoder to memory
    logic                 memWe;
    logic                 memRe;
    memIoPkg::memIoAddr_u memAddr;
    logic [31:0]          memWdata;
    logic [31:0]          memRdata;

    // decoder to board I/O
    logic        ioWe;
    logic        ioRe;
    logic        ecallPrint;
    logic        ecallRead;
    logic [7:0]  ioOfs;
    logic [31:0] ioWdata;
    logic [31:0] ioRdata;

    memOrIo uDecode (
        .clk        (clk),
        .rstN       (rstN),
        .mRead      (mRead),
        .mWrite     (mWrite),
        .aluResult  (aluResult),
        .rRdata     (rRdata),
        .ecallValid (ecallValid),
        .ecallOp    (ecallOp),
        .ecallA0    (ecallA0),
        .memRdata   (memRdata),
        .ioRdata    (ioRdata),
        .memWe      (memWe),
        .memRe      (memRe),
        .memAddr    (memAddr),
        .ioWe       (ioWe),
        .ioRe       (ioRe),
        .ecallPrint (ecallPrint),
        .ecallRead  (ecallRead),
        .ioOfs      (ioOfs),
        .memWdata   (memWdata),
        .ioWdata    (ioWdata),
        .rWdata     (rWdata)
    );

    dataMem uMem (
        .clk      (clk),
        .memWe    (memWe),
        .memRe    (memRe),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRdata (memRdata)
    );

    ioPorts uIo (
        .clk        (clk),
        .rstN       (rstN),
        .ioWe       (ioWe),
        .ioRe       (ioRe),
        .ecallPrint (ecallPrint),
        .ecallRead  (ecallRead),
        .ioOfs      (ioOfs),
        .ioWdata    (ioWdata),
        .switchIn   (switchIn),
        .keyIn      (keyIn),
        .btnIn      (btnIn),
        .ioRdata    (ioRdata),
        .led        (led),
        .seg        (seg)
    );

endmodule

`default_nettype wire

// ==== memIoTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memio_consts.svh"

module memIoTb;

    localparam logic [31:0] aliasStep = 32'h1 << (`MEM_ADDR_BITS + 2);   // one memory size

    logic        clk;
    logic        rstN;
    logic        mRead;
    logic        mWrite;
    logic [31:0] aluResult;
    logic [31:0] rRdata;
    logic        ecallValid;
    logic [1:0]  ecallOp;
    logic [31:0] ecallA0;
    logic [11:0] switchIn;
    logic [3:0]  keyIn;
    logic        btnIn;
    logic [31:0] rWdata;
    logic [23:0] led;
    logic [31:0] seg;

    // reference model
    logic [31:0] refMem [0:(1 << `MEM_ADDR_BITS)-1];
    logic [23:0] refLed;
    logic [31:0] refSeg;
    logic [11:0] boardSw;
    logic [3:0]  boardKey;
    logic        boardBtn;

    // pend is the cycle just driven and due the one checked at this negedge
    logic        pendValid;
    logic [31:0] pendRw;
    logic [23:0] pendLed;
    logic [31:0] pendSeg;
    logic        dueValid;
    logic [31:0] dueRw;
    logic [23:0] dueLed;
    logic [31:0] dueSeg;

    integer      seed;
    int          errors;
    int          checks;
    logic [31:0] storedAddr [$];

    memIoTop uut (
        .clk        (clk),
        .rstN       (rstN),
        .mRead      (mRead),
        .mWrite     (mWrite),
        .aluResult  (aluResult),
        .rRdata     (rRdata),
        .ecallValid (ecallValid),
        .ecallOp    (ecallOp),
        .ecallA0    (ecallA0),
        .switchIn   (switchIn),
        .keyIn      (keyIn),
        .btnIn      (btnIn),
        .rWdata     (rWdata),
        .led        (led),
        .seg        (seg)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // word a load of addr returns one cycle later
    function automatic logic [31:0] expectedRead(input logic [31:0] addr);
        logic [31:0] word;
        word = 32'h0;
        if (addr[31:8] == `IO_PAGE) begin
            case (addr[7:0])
                `SWITCH_OFS: word = {20'h0, boardSw};
                `KEY_OFS:    word = {28'h0, boardKey};
                `BTN_OFS:    word = {31'h0, boardBtn};
                default:     word = 32'h0;   // write-only or unmapped
            endcase
        end else begin
            word = refMem[addr[`MEM_ADDR_BITS+1:2]];   // upper bits wrap
        end
        return word;
    endfunction

    function automatic logic [31:0] ioAddr(input logic [7:0] ofs);
        return {`IO_PAGE, ofs};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checks++;
        if (actVal !== expVal) begin
            errors++;
            $display("Fail at time %0t: %s expected %h, actual %h", $time, name, expVal, actVal);
        end
    endtask

    task automatic abortOnTimeout(input string what);
        errors++;
        $display("Error: gave up waiting for %s, the simulation is stopped", what);
        $display("checks %0d, errors %0d", checks, errors);
        $display(">>> FAIL");
        $finish;
    endtask

    // drive one clock of stimulus and update the model by the same rules
    task automatic driveCycle(input logic rd, input logic wr, input logic [31:0] addr,
                              input logic [31:0] data, input logic ev,
                              input logic [1:0] op, input logic [31:0] a0);
        logic [31:0] expRw;
        expRw = 32'h0;
        if (ev) begin   // ecall wins over any strobe
            if (op == `ECALL_PRINT_INT) begin
                refLed = a0[23:0];
            end else if (op == `ECALL_READ_INT) begin
                expRw = {20'h0, boardSw};
            end
        end else if (wr) begin
            if (addr[31:8] == `IO_PAGE) begin
                if (addr[7:0] == `LED_OFS) begin
                    refLed = data[23:0];
                end else if (addr[7:0] == `SEG_OFS) begin
                    refSeg = data;
                end
            end else begin
                refMem[addr[`MEM_ADDR_BITS+1:2]] = data;
            end
        end else if (rd) begin
            expRw = expectedRead(addr);
        end
        @(posedge clk);
        mRead      <= rd;
        mWrite     <= wr;
        aluResult  <= addr;
        rRdata     <= data;
        ecallValid <= ev;
        ecallOp    <= op;
        ecallA0    <= a0;
        switchIn   <= boardSw;
        keyIn      <= boardKey;
        btnIn      <= boardBtn;
        pendValid = 1'b1;
        pendRw    = expRw;
        pendLed   = refLed;
        pendSeg   = refSeg;
    endtask

    task automatic loadWord(input logic [31:0] addr);
        driveCycle(1'b1, 1'b0, addr, 32'h0, 1'b0, 2'd0, 32'h0);
    endtask

    task automatic storeWord(input logic [31:0] addr, input logic [31:0] data);
        driveCycle(1'b0, 1'b1, addr, data, 1'b0, 2'd0, 32'h0);
    endtask

    task automatic idle();
        driveCycle(1'b0, 1'b0, 32'h0, 32'h0, 1'b0, 2'd0, 32'h0);
    endtask

    // ecall plus a store strobe that the DUT must drop
    task automatic callEnv(input logic [1:0] op, input logic [31:0] a0,
                           input logic [31:0] addr, input logic [31:0] data);
        driveCycle(1'b0, 1'b1, addr, data, 1'b1, op, a0);
    endtask

    task automatic setBoard(input logic [11:0] sw, input logic [3:0] key, input logic btn);
        boardSw  = sw;
        boardKey = key;
        boardBtn = btn;
        repeat (4) idle();   // two synchronizer stages plus margin
    endtask

    initial begin : compareProc
        int waitCycles;
        waitCycles = 0;
        dueValid   = 1'b0;
        while (rstN !== 1'b1 && waitCycles <= 40) begin
            @(negedge clk);
            waitCycles++;
        end
        if (rstN !== 1'b1) begin
            abortOnTimeout("the end of reset");
        end else begin
            forever begin
                @(negedge clk);   // outputs settled mid-cycle
                if (dueValid) begin
                    checkValue("rWdata", dueRw, rWdata);
                    checkValue("led", {8'h0, dueLed}, {8'h0, led});
                    checkValue("seg", dueSeg, seg);
                end
                dueValid  = pendValid;
                dueRw     = pendRw;
                dueLed    = pendLed;
                dueSeg    = pendSeg;
                pendValid = 1'b0;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] a0;
        int          drainCycles;
        seed       = 32'h95f05375;
        errors     = 0;
        checks     = 0;
        rstN       = 1'b0;
        mRead      = 1'b0;
        mWrite     = 1'b0;
        aluResult  = 32'h0;
        rRdata     = 32'h0;
        ecallValid = 1'b0;
        ecallOp    = 2'd0;
        ecallA0    = 32'h0;
        switchIn   = 12'h0;
        keyIn      = 4'h0;
        btnIn      = 1'b0;
        refLed     = 24'h0;
        refSeg     = 32'h0;
        boardSw    = 12'h0;
        boardKey   = 4'h0;
        boardBtn   = 1'b0;
        pendValid  = 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        repeat (2) idle();   // reset state is all zero

        // memory round trip
        for (int i = 0; i < 16; i++) begin
            addr      = $random(seed);
            addr[31]  = 1'b0;   // never the I/O page
            addr[1:0] = 2'b00;
            data      = $random(seed);
            storeWord(addr, data);
            storedAddr.push_back(addr);
        end
        foreach (storedAddr[i]) begin
            loadWord(storedAddr[i]);   // back to back so two are in flight
        end
        for (int i = 0; i < 4; i++) begin
            loadWord(storedAddr[i] ^ aliasStep);
        end
        storeWord(storedAddr[0] ^ aliasStep, 32'hA5A5_0F0F);
        loadWord(storedAddr[0]);
        idle();

        // I/O loads
        for (int i = 0; i < 3; i++) begin
            data = $random(seed);
            setBoard(data[11:0], data[15:12], data[16]);
            loadWord(ioAddr(`SWITCH_OFS));
            loadWord(ioAddr(`KEY_OFS));
            loadWord(ioAddr(`BTN_OFS));
            loadWord(ioAddr(8'h40));
            loadWord(ioAddr(`LED_OFS));
        end
        idle();

        // I/O stores must leave memory words with the same low bits alone
        storeWord({24'h0, `LED_OFS}, 32'h1234_5678);
        storeWord({24'h0, `SEG_OFS}, 32'h9ABC_DEF0);
        for (int i = 0; i < 3; i++) begin
            data = $random(seed);
            storeWord(ioAddr(`LED_OFS), data);
            data = $random(seed);
            storeWord(ioAddr(`SEG_OFS), data);
        end
        storeWord(ioAddr(`SWITCH_OFS), 32'hFFFF_FFFF);   // read only
        storeWord(ioAddr(8'h44), 32'h5555_5555);
        loadWord({24'h0, `LED_OFS});
        loadWord({24'h0, `SEG_OFS});
        loadWord(ioAddr(`SWITCH_OFS));
        idle();

        // ecalls
        for (int i = 0; i < 3; i++) begin
            a0   = $random(seed);
            data = $random(seed);
            callEnv(`ECALL_PRINT_INT, a0, ioAddr(`LED_OFS), data);
        end
        a0 = $random(seed);
        callEnv(`ECALL_PRINT_INT, a0, {24'h0, `LED_OFS}, 32'hDEAD_BEEF);
        loadWord({24'h0, `LED_OFS});
        data = $random(seed);
        setBoard(data[11:0], data[15:12], data[16]);
        callEnv(`ECALL_READ_INT, 32'h0, ioAddr(`SEG_OFS), 32'h0BAD_0BAD);
        loadWord(storedAddr[1]);
        callEnv(`ECALL_READ_INT, 32'h0, 32'h0, 32'h0);
        repeat (3) idle();

        drainCycles = 0;
        while ((pendValid || dueValid) && drainCycles <= 10) begin
            @(posedge clk);
            drainCycles++;
        end
        if (pendValid || dueValid) begin
            abortOnTimeout("the last checks");
        end else begin
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0 && checks > 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
memIoPkg.sv
dataMem.sv
ioPorts.sv
memOrIo.sv
memIoTop.sv
memIoTb.sv

// ==== run.sh ====
#!/bin/sh
# build the memIoTop testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module memIoTb -o memIoSim

./obj_dir/memIoSim > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi

echo "simulation finished without errors"
exit 0
